// ==== rtl/mac_acc_negator_block.sv ====
module mac_acc_negator_block (
  input  logic               clk,
  input  logic               reset,
  input  logic               en,
  input  mac_pkg::mac_cfg_t  cfg,
  input  mac_pkg::acc_word_u c_in,
  input  mac_pkg::mac_neg_t  neg,
  output mac_pkg::acc_word_u c_out
);
  import mac_pkg::*;

  mac_mode_e                        mode;
  logic                             single;
  logic                             dual;
  logic                             quad;
  logic [LANES-1:0]                 lane_cin;
  logic [LANES-1:0]                 lane_cout;
  logic [LANES-1:0]                 lane_sel;
  logic [LANES-1:0][LANE_ACC_W-1:0] lane_bar;

  assign mode   = mode_of(cfg);
  assign quad   = (mode == mode_quad);
  assign dual   = (mode == mode_dual);
  assign single = ~(quad | dual);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Segmented invert-and-increment chain
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign lane_cin[0] = 1'b1;
  assign lane_cin[1] = single ? 1'b1 : lane_cout[0];
  assign lane_cin[2] = quad ? lane_cout[1] : 1'b1;   // Pair boundary
  assign lane_cin[3] = single ? 1'b1 : lane_cout[2];

  for (genvar i = 0; i < LANES; i++) begin : g_lane
    n_bit_acc_negator_adder #(
      .N(LANE_ACC_W)
    ) u_adder (
      .A    (~c_in.lane[i]),
      .cin  (lane_cin[i]),
      .SUM  (lane_bar[i]),
      .PG   (),
      .cout (lane_cout[i])
    );
  end

  // Each lane follows the flag at the top of its segment
  assign lane_sel[0] = (single & neg[0]) | (dual & neg[1]) | (quad & neg[3]);
  assign lane_sel[1] = (~quad & neg[1]) | (quad & neg[3]);
  assign lane_sel[2] = (single & neg[2]) | (~single & neg[3]);
  assign lane_sel[3] = neg[3];

  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      c_out.lane[i] = (lane_sel[i] & cfg.is_signed) ? lane_bar[i] : c_in.lane[i];
    end
  end

  // Mode may not change between back-to-back products
  cfg_hold: assert property (@(posedge clk) disable iff (reset)
    en && $past(en) |-> $stable(cfg));

endmodule

// ==== rtl/mac_accumulator.sv ====
module mac_accumulator (
  input  logic               clk,
  input  logic               reset,
  input  logic               acc_clear,
  input  logic               prod_valid,
  input  mac_pkg::mac_cfg_t  prod_cfg,
  input  mac_pkg::acc_word_u addend,
  output mac_pkg::acc_word_u acc
);
  import mac_pkg::*;

  mac_mode_e        mode;
  logic [LANES-1:0] cut;    // Carry into lane i is dropped
  acc_word_u        sum;

  assign mode = mode_of(prod_cfg);
  assign cut  = {mode == mode_single, mode != mode_quad, mode == mode_single, 1'b1};

  // Ripple lane by lane, wrapping at segment tops
  always_comb begin
    logic [LANE_ACC_W:0] lane_sum;
    logic                carry;
    carry    = 1'b0;
    lane_sum = '0;
    for (int i = 0; i < LANES; i++) begin
      if (cut[i]) carry = 1'b0;
      lane_sum = {1'b0, acc.lane[i]} + {1'b0, addend.lane[i]}
               + (LANE_ACC_W+1)'(carry);
      sum.lane[i] = lane_sum[LANE_ACC_W-1:0];
      carry       = lane_sum[LANE_ACC_W];
    end
  end

  always_ff @(posedge clk) begin
    if (reset || acc_clear) begin
      acc <= '0;
    end else if (prod_valid) begin
      acc <= prod_cfg.accumulate ? sum : addend;   // Multiply only overwrites
    end
  end

endmodule

// ==== rtl/mac_beat_counter.sv ====
module mac_beat_counter #(
  parameter int COUNT_W = 8
) (
  input  logic               clk,
  input  logic               reset,
  input  logic               load,
  input  logic [COUNT_W-1:0] load_value,
  input  logic               dec,
  output logic               zero
);

  logic [COUNT_W-1:0] count;

  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else if (load) begin
      count <= load_value;
    end else if (dec && count != '0) begin
      count <= count - COUNT_W'(1);   // Sticks at zero
    end
  end

  assign zero = (count == '0);

  // Controller only steps a live count
  no_dec_at_zero: assert property (@(posedge clk) disable iff (reset)
    dec |-> !zero);

endmodule

// ==== rtl/mac_ctrl_fsm.sv ====
module mac_ctrl_fsm #(
  parameter int COUNT_W = 8
) (
  input  logic               clk,
  input  logic               reset,
  input  logic               cmd_valid,
  output logic               cmd_ready,
  input  mac_pkg::mac_cfg_t  cmd_cfg,
  input  logic [COUNT_W-1:0] cmd_beats,
  input  logic               beat_valid,
  output logic               beat_ready,
  output logic               res_valid,
  input  logic               res_ready,
  output logic               cnt_load,
  output logic [COUNT_W-1:0] cnt_value,
  output logic               cnt_dec,
  input  logic               cnt_zero,
  output logic               advance,
  output logic               acc_clear,
  output mac_pkg::mac_cfg_t  cfg
);

  // Splitter, multiplier and accumulator stages
  localparam logic [COUNT_W-1:0] DRAIN_CYCLES = COUNT_W'(3);

  typedef enum logic [1:0] {idle, feed, drain, result} state_e;

  state_e state;
  state_e state_d;
  logic   cmd_fire;
  logic   beat_fire;
  logic   res_fire;

  assign cmd_fire  = cmd_valid & cmd_ready;
  assign beat_fire = beat_valid & beat_ready;
  assign res_fire  = res_valid & res_ready;

  always_comb begin
    state_d   = state;
    cnt_load  = 1'b0;
    cnt_value = DRAIN_CYCLES;
    cnt_dec   = 1'b0;
    acc_clear = 1'b0;
    case (state)
      idle: begin
        if (cmd_fire) begin
          state_d   = feed;
          cnt_load  = 1'b1;
          acc_clear = 1'b1;
          // Counter holds beats still to come after the current one
          cnt_value = (cmd_beats == '0) ? '0 : cmd_beats - COUNT_W'(1);
        end
      end
      feed: begin
        if (beat_fire) begin
          if (cnt_zero) begin
            state_d  = drain;   // Last beat, reload with drain count
            cnt_load = 1'b1;
          end else begin
            cnt_dec = 1'b1;
          end
        end
      end
      drain: begin
        if (cnt_zero) state_d = result;
        else cnt_dec = 1'b1;
      end
      result: begin
        if (res_fire) state_d = idle;
      end
      default: state_d = idle;
    endcase
  end

  assign advance = (state == feed) || (state == drain);

  // Handshake outputs come straight from flops
  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= idle;
      cmd_ready  <= 1'b0;
      beat_ready <= 1'b0;
      res_valid  <= 1'b0;
      cfg        <= '0;
    end else begin
      state      <= state_d;
      cmd_ready  <= (state_d == idle);
      beat_ready <= (state_d == feed);
      res_valid  <= (state_d == result);
      if (cmd_fire) cfg <= cmd_cfg;   // Held for the whole job
    end
  end

  res_hold: assert property (@(posedge clk) disable iff (reset)
    res_valid && !res_ready |=> res_valid);

endmodule

// ==== rtl/mac_lane_multiplier.sv ====
module mac_lane_multiplier (
  input  logic               clk,
  input  logic               reset,
  input  logic               advance,
  input  mac_pkg::mac_mag_t  mag,
  input  logic               mag_valid,
  output mac_pkg::acc_word_u prod,
  output mac_pkg::mac_neg_t  neg,
  output mac_pkg::mac_cfg_t  prod_cfg,
  output logic               prod_valid
);
  import mac_pkg::*;

  mac_mode_e                      mode;
  logic [3:0][3:0][2*MIN_W-1:0]   pp;       // pp[i][j] = a byte i times b byte j
  logic [1:0][4*MIN_W-1:0]        dual_p;
  logic [8*MIN_W-1:0]             quad_p;
  acc_word_u                      prod_d;

  assign mode = mode_of(mag.cfg);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Partial products and per-mode sums
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      for (int j = 0; j < 4; j++) begin
        pp[i][j] = mag.a[MIN_W*i +: MIN_W] * mag.b[MIN_W*j +: MIN_W];
      end
    end

    // 16x16 per half, cross terms shifted one byte
    for (int k = 0; k < 2; k++) begin
      dual_p[k] = (4*MIN_W)'(pp[2*k][2*k])
                + ((4*MIN_W)'(pp[2*k+1][2*k]) << MIN_W)
                + ((4*MIN_W)'(pp[2*k][2*k+1]) << MIN_W)
                + ((4*MIN_W)'(pp[2*k+1][2*k+1]) << (2*MIN_W));
    end

    quad_p = '0;
    for (int i = 0; i < 4; i++) begin
      for (int j = 0; j < 4; j++) begin
        quad_p = quad_p + ((8*MIN_W)'(pp[i][j]) << (MIN_W * (i + j)));
      end
    end
  end

  always_comb begin
    prod_d = '0;
    case (mode)
      mode_quad: prod_d.pair[0] = quad_p;
      mode_dual: begin
        for (int k = 0; k < 2; k++) prod_d.pair[k] = (2*LANE_ACC_W)'(dual_p[k]);
      end
      default: begin
        for (int i = 0; i < LANES; i++) prod_d.lane[i] = LANE_ACC_W'(pp[i][i]);  // Diagonal
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) prod_valid <= 1'b0;
    else if (advance) prod_valid <= mag_valid;
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      prod     <= prod_d;
      neg      <= mag.neg;
      prod_cfg <= mag.cfg;
    end
  end

endmodule

// ==== rtl/mac_pkg.sv ====
package mac_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Widths fixed by the lane arithmetic
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int MIN_W      = 8;            // Narrowest operand lane
  localparam int WORD_W     = 4 * MIN_W;    // One operand word
  localparam int LANE_ACC_W = 32;           // Accumulator slice per lane
  localparam int ACC_W      = 128;
  localparam int LANES      = ACC_W / LANE_ACC_W;

  typedef enum logic [1:0] {
    mode_single = 2'b00,
    mode_dual   = 2'b01,
    mode_quad   = 2'b10
  } mac_mode_e;

  // Bit 3 signed, bit 2 accumulate, bits 1:0 lane mode
  typedef struct packed {
    logic      is_signed;
    logic      accumulate;
    mac_mode_e mode;
  } mac_cfg_t;

  // Four 32-bit lanes, or two 64-bit pairs for dual
  typedef union packed {
    logic [LANES-1:0][LANE_ACC_W-1:0]     lane;
    logic [LANES/2-1:0][2*LANE_ACC_W-1:0] pair;
  } acc_word_u;

  typedef struct packed {
    mac_cfg_t   cfg;
    logic [7:0] beats;   // Zero runs as one beat
  } mac_cmd_t;

  typedef struct packed {
    logic [WORD_W-1:0] a;
    logic [WORD_W-1:0] b;
  } mac_beat_t;

  typedef logic [LANES-1:0] mac_neg_t;

  // Splitter output, lane magnitudes plus sign info
  typedef struct packed {
    logic [WORD_W-1:0] a;
    logic [WORD_W-1:0] b;
    mac_neg_t          neg;
    mac_cfg_t          cfg;
  } mac_mag_t;

  // The spare code 11 runs as single
  function automatic mac_mode_e mode_of(mac_cfg_t cfg);
    if (cfg.mode == mode_dual || cfg.mode == mode_quad) begin
      return cfg.mode;
    end
    return mode_single;
  endfunction

endpackage

// ==== rtl/mac_sign_splitter.sv ====
module mac_sign_splitter (
  input  logic               clk,
  input  logic               reset,
  input  logic               advance,
  input  mac_pkg::mac_cfg_t  cfg,
  input  mac_pkg::mac_beat_t beat,
  input  logic               in_valid,
  output mac_pkg::mac_mag_t  mag,
  output logic               mag_valid
);
  import mac_pkg::*;

  mac_mode_e mode;
  mac_mag_t  mag_d;

  // Absolute value of every lane at the mode's width
  function automatic logic [WORD_W-1:0] lane_abs(logic [WORD_W-1:0] w, mac_mode_e m);
    logic [WORD_W-1:0] r;
    r = w;
    case (m)
      mode_quad: if (w[WORD_W-1]) r = -w;
      mode_dual: begin
        for (int i = 0; i < 2; i++) begin
          if (w[2*MIN_W*i + 2*MIN_W-1]) r[2*MIN_W*i +: 2*MIN_W] = -w[2*MIN_W*i +: 2*MIN_W];
        end
      end
      default: begin
        for (int i = 0; i < 4; i++) begin
          if (w[MIN_W*i + MIN_W-1]) r[MIN_W*i +: MIN_W] = -w[MIN_W*i +: MIN_W];
        end
      end
    endcase
    return r;
  endfunction

  // Flag sits in the top lane of its segment
  function automatic mac_neg_t sign_flags(logic [WORD_W-1:0] a, logic [WORD_W-1:0] b,
                                          mac_mode_e m);
    mac_neg_t f;
    f = '0;
    case (m)
      mode_quad: f[3] = a[WORD_W-1] ^ b[WORD_W-1];
      mode_dual: begin
        f[1] = a[2*MIN_W-1] ^ b[2*MIN_W-1];
        f[3] = a[WORD_W-1] ^ b[WORD_W-1];
      end
      default: begin
        for (int i = 0; i < 4; i++) f[i] = a[MIN_W*i + MIN_W-1] ^ b[MIN_W*i + MIN_W-1];
      end
    endcase
    return f;
  endfunction

  assign mode = mode_of(cfg);

  always_comb begin
    mag_d.cfg = cfg;
    if (cfg.is_signed) begin
      mag_d.a   = lane_abs(beat.a, mode);
      mag_d.b   = lane_abs(beat.b, mode);
      mag_d.neg = sign_flags(beat.a, beat.b, mode);
    end else begin
      mag_d.a   = beat.a;
      mag_d.b   = beat.b;
      mag_d.neg = '0;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) mag_valid <= 1'b0;
    else if (advance) mag_valid <= in_valid;
  end

  always_ff @(posedge clk) begin
    if (advance) mag <= mag_d;
  end

endmodule

// ==== rtl/mac_top.sv ====
module mac_top #(
  parameter int COUNT_W = 8
) (
  input  logic               clk,
  input  logic               reset,
  input  logic               cmd_valid,
  output logic               cmd_ready,
  input  mac_pkg::mac_cmd_t  cmd,
  input  logic               beat_valid,
  output logic               beat_ready,
  input  mac_pkg::mac_beat_t beat,
  output logic               res_valid,
  input  logic               res_ready,
  output mac_pkg::acc_word_u res
);
  import mac_pkg::*;

  logic               cnt_load;
  logic [COUNT_W-1:0] cnt_value;
  logic               cnt_dec;
  logic               cnt_zero;
  logic               advance;
  logic               acc_clear;
  mac_cfg_t           cfg;
  mac_mag_t           mag;
  logic               mag_valid;
  acc_word_u          prod;
  mac_neg_t           neg;
  mac_cfg_t           prod_cfg;
  logic               prod_valid;
  acc_word_u          addend;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Control
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  mac_ctrl_fsm #(
    .COUNT_W(COUNT_W)
  ) u_ctrl (
    .clk        (clk),
    .reset      (reset),
    .cmd_valid  (cmd_valid),
    .cmd_ready  (cmd_ready),
    .cmd_cfg    (cmd.cfg),
    .cmd_beats  (COUNT_W'(cmd.beats)),
    .beat_valid (beat_valid),
    .beat_ready (beat_ready),
    .res_valid  (res_valid),
    .res_ready  (res_ready),
    .cnt_load   (cnt_load),
    .cnt_value  (cnt_value),
    .cnt_dec    (cnt_dec),
    .cnt_zero   (cnt_zero),
    .advance    (advance),
    .acc_clear  (acc_clear),
    .cfg        (cfg)
  );

  mac_beat_counter #(
    .COUNT_W(COUNT_W)
  ) u_counter (
    .clk        (clk),
    .reset      (reset),
    .load       (cnt_load),
    .load_value (cnt_value),
    .dec        (cnt_dec),
    .zero       (cnt_zero)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Datapath
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  mac_sign_splitter u_splitter (
    .clk       (clk),
    .reset     (reset),
    .advance   (advance),
    .cfg       (cfg),
    .beat      (beat),
    .in_valid  (beat_valid & beat_ready),   // Accepted beats only
    .mag       (mag),
    .mag_valid (mag_valid)
  );

  mac_lane_multiplier u_mult (
    .clk        (clk),
    .reset      (reset),
    .advance    (advance),
    .mag        (mag),
    .mag_valid  (mag_valid),
    .prod       (prod),
    .neg        (neg),
    .prod_cfg   (prod_cfg),
    .prod_valid (prod_valid)
  );

  mac_acc_negator_block u_negator (
    .clk   (clk),
    .reset (reset),
    .en    (prod_valid),
    .cfg   (prod_cfg),
    .c_in  (prod),
    .neg   (neg),
    .c_out (addend)
  );

  mac_accumulator u_acc (
    .clk        (clk),
    .reset      (reset),
    .acc_clear  (acc_clear),
    .prod_valid (prod_valid),
    .prod_cfg   (prod_cfg),
    .addend     (addend),
    .acc        (res)
  );

endmodule

// ==== rtl/n_bit_acc_negator_adder.sv ====
module n_bit_acc_negator_adder #(
  parameter int N = 32
) (
  input  logic [N-1:0] A,
  input  logic         cin,
  output logic [N-1:0] SUM,
  output logic [1:0]   PG,    // {group propagate, group generate}
  output logic         cout
);

  localparam int LEVELS = $clog2(N);

  // pre[l][i] is the AND of A over a span of 2**l bits ending at i
  logic [LEVELS:0][N-1:0] pre;
  logic [N-1:0]           carry;

  assign pre[0] = A;

  for (genvar l = 0; l < LEVELS; l++) begin : g_level
    for (genvar i = 0; i < N; i++) begin : g_bit
      if (i >= (1 << l)) begin : g_merge
        assign pre[l+1][i] = pre[l][i] & pre[l][i - (1 << l)];
      end else begin : g_pass
        assign pre[l+1][i] = pre[l][i];
      end
    end
  end

  assign carry = {pre[LEVELS][N-2:0], 1'b1} & {N{cin}};
  assign SUM   = A ^ carry;
  assign PG    = {pre[LEVELS][N-1], cin & pre[LEVELS][N-1]};
  assign cout  = PG[0];   // Generate already folds in cin

endmodule

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --assert -j 0 --top-module tb_mac_top -f sim.f -o tb_mac_top &&
./obj_dir/tb_mac_top | tee /dev/stderr | grep -q -F -x "PASS: all tests" &&
echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

// ==== sim.f ====
+incdir+tests
rtl/mac_pkg.sv
rtl/n_bit_acc_negator_adder.sv
rtl/mac_beat_counter.sv
rtl/mac_ctrl_fsm.sv
rtl/mac_sign_splitter.sv
rtl/mac_lane_multiplier.sv
rtl/mac_acc_negator_block.sv
rtl/mac_accumulator.sv
rtl/mac_top.sv
tests/tb_mac_top.sv

// ==== tests/mac_model.svh ====
`ifndef MAC_MODEL_SVH
`define MAC_MODEL_SVH

// Lane mode of a cfg, spare code 11 runs as single
function automatic logic [1:0] model_mode(input mac_cfg_t cfg);
  logic [1:0] m;
  m = cfg.mode;
  return (m == 2'b11) ? 2'b00 : m;
endfunction

// Full product of one beat, each segment extended to its accumulator width
function automatic acc_word_u model_product(input mac_cfg_t cfg, input mac_beat_t bt);
  acc_word_u    r;
  logic [7:0]   xb;
  logic [7:0]   yb;
  logic [15:0]  xh;
  logic [15:0]  yh;
  logic [31:0]  x32;
  logic [31:0]  y32;
  logic [63:0]  x64;
  logic [63:0]  y64;
  logic [127:0] x128;
  logic [127:0] y128;
  r = '0;
  case (model_mode(cfg))
    2'b10: begin
      x128   = cfg.is_signed ? {{96{bt.a[31]}}, bt.a} : {96'h0, bt.a};
      y128   = cfg.is_signed ? {{96{bt.b[31]}}, bt.b} : {96'h0, bt.b};
      r.lane = x128 * y128;   // Wraps at 128 bits
    end
    2'b01: begin
      for (int k = 0; k < 2; k++) begin
        xh        = bt.a[16*k +: 16];
        yh        = bt.b[16*k +: 16];
        x64       = cfg.is_signed ? {{48{xh[15]}}, xh} : {48'h0, xh};
        y64       = cfg.is_signed ? {{48{yh[15]}}, yh} : {48'h0, yh};
        r.pair[k] = x64 * y64;
      end
    end
    default: begin
      for (int i = 0; i < 4; i++) begin
        xb        = bt.a[8*i +: 8];
        yb        = bt.b[8*i +: 8];
        x32       = cfg.is_signed ? {{24{xb[7]}}, xb} : {24'h0, xb};
        y32       = cfg.is_signed ? {{24{yb[7]}}, yb} : {24'h0, yb};
        r.lane[i] = x32 * y32;
      end
    end
  endcase
  return r;
endfunction

// Add per segment with wrap, or take the product alone
function automatic acc_word_u model_step(input mac_cfg_t cfg, input acc_word_u acc,
                                         input acc_word_u p);
  acc_word_u    r;
  logic [127:0] acc_flat;
  logic [127:0] p_flat;
  if (!cfg.accumulate) begin
    return p;
  end
  r        = '0;
  acc_flat = acc;
  p_flat   = p;
  case (model_mode(cfg))
    2'b10: r.lane = acc_flat + p_flat;
    2'b01: begin
      for (int k = 0; k < 2; k++) r.pair[k] = acc.pair[k] + p.pair[k];
    end
    default: begin
      for (int i = 0; i < 4; i++) r.lane[i] = acc.lane[i] + p.lane[i];
    end
  endcase
  return r;
endfunction

`endif

// ==== tests/tb_mac_top.sv ====
module tb_mac_top;
  import mac_pkg::*;

  `include "mac_model.svh"

  localparam int JOBS_MAX       = 64;
  localparam int BEATS_MAX      = 255;
  localparam int TIMEOUT_CYCLES = JOBS_MAX * (BEATS_MAX + 10);
  localparam int RES_DELAY      = 4;    // Edges from last beat to res_valid

  logic       clk;
  logic       reset;
  logic       cmd_valid;
  logic       cmd_ready;
  mac_cmd_t   cmd;
  logic       beat_valid;
  logic       beat_ready;
  mac_beat_t  beat;
  logic       res_valid;
  logic       res_ready;
  acc_word_u  res;
  logic [2:0] hs;                       // {cmd_ready, beat_ready, res_valid}

  int cycles = 0;
  int checks = 0;
  int errors = 0;

  assign hs = {cmd_ready, beat_ready, res_valid};

  mac_top #(
    .COUNT_W(8)
  ) UUT (
    .clk        (clk),
    .reset      (reset),
    .cmd_valid  (cmd_valid),
    .cmd_ready  (cmd_ready),
    .cmd        (cmd),
    .beat_valid (beat_valid),
    .beat_ready (beat_ready),
    .beat       (beat),
    .res_valid  (res_valid),
    .res_ready  (res_ready),
    .res        (res)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles > TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Compare tasks and helpers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic check_result(input acc_word_u got, input acc_word_u exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at time %0t: %s, res %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_handshake(input logic [2:0] got, input logic [2:0] exp,
                                 input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at time %0t: %s, ready/valid %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic report_test(input int num, input string name, input int errs_before);
    if (errors == errs_before) $display("Test %0d %s: passed", num, name);
    else $display("Test %0d %s: failed, %0d errors", num, name, errors - errs_before);
  endtask

  // Random word, or lanes forced to edge values at the mode's width
  function automatic logic [31:0] pick_word(input logic [1:0] mode, input bit extremes);
    logic [31:0] w;
    int          lw;
    int          kind [4];
    int          pos;
    w = $urandom;
    if (extremes && $urandom_range(0, 1) == 1) begin
      lw = (mode == 2'b10) ? 32 : (mode == 2'b01) ? 16 : 8;
      for (int i = 0; i < 4; i++) kind[i] = $urandom_range(0, 3);
      for (int bi = 0; bi < 32; bi++) begin
        pos = bi % lw;
        case (kind[bi / lw])
          0:       w[bi] = (pos == lw - 1);   // Most negative
          1:       w[bi] = 1'b1;              // Minus one
          2:       w[bi] = (pos != lw - 1);   // Most positive
          default: w[bi] = 1'b0;              // Zero carries through the negator chain
        endcase
      end
    end
    return w;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // One job, command to result hand-off
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic run_job(input logic [1:0] mode, input bit sgn, input bit acc,
                         input int n_field, input bit gaps, input bit extremes);
    mac_cfg_t  cfg;
    mac_beat_t beats_q[$];
    mac_beat_t bt;
    acc_word_u exp;
    acc_word_u first;
    int        n;
    int        idx;
    int        wait_n;
    bit        hold;
    string     tag;
    cfg = mac_cfg_t'({sgn, acc, mode});
    n   = (n_field == 0) ? 1 : n_field;   // Zero beats runs as one
    exp = '0;
    for (int i = 0; i < n; i++) begin
      bt.a = pick_word(mode, extremes);
      bt.b = pick_word(mode, extremes);
      beats_q.push_back(bt);
      exp = model_step(cfg, exp, model_product(cfg, bt));
    end
    tag = $sformatf("mode %0d signed %0d acc %0d beats %0d", mode, sgn, acc, n_field);

    cmd_valid <= 1'b1;
    cmd.cfg   <= cfg;
    cmd.beats <= 8'(n_field);
    do @(posedge clk); while (!cmd_ready);
    cmd_valid <= 1'b0;

    idx  = 0;
    hold = 1'b0;
    while (idx < n) begin
      if (hold || !gaps || $urandom_range(0, 3) != 0) begin
        beat_valid <= 1'b1;
        beat       <= beats_q[idx];
      end else begin
        beat_valid <= 1'b0;   // Gap
      end
      @(posedge clk);
      hold = beat_valid && !beat_ready;
      if (beat_valid && beat_ready) idx++;
    end
    beat_valid <= 1'b0;

    // Three pipeline stages plus the RESULT entry
    repeat (RES_DELAY) begin
      @(posedge clk);
      check_handshake(hs, 3'b000, {tag, ", drain"});
    end
    @(posedge clk);
    check_handshake(hs, 3'b001, {tag, ", result raised"});

    first  = res;
    wait_n = gaps ? $urandom_range(0, 3) : 0;
    repeat (wait_n) begin
      @(posedge clk);
      check_handshake(hs, 3'b001, {tag, ", result held"});
      check_result(res, first, {tag, ", result stable"});
    end
    res_ready <= 1'b1;
    do @(posedge clk); while (!res_valid);
    check_result(res, exp, tag);
    res_ready <= 1'b0;
    @(posedge clk);
    check_handshake(hs, 3'b100, {tag, ", single result"});
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Test sequence
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial begin
    int base;
    void'($urandom(32'h58b1_aa9a));
    reset      <= 1'b1;
    cmd_valid  <= 1'b0;
    cmd        <= '0;
    beat_valid <= 1'b0;
    beat       <= '0;
    res_ready  <= 1'b0;
    repeat (3) @(posedge clk);
    reset <= 1'b0;

    base = errors;
    @(posedge clk);
    check_handshake(hs, 3'b000, "first edge after reset");
    repeat (3) begin
      @(posedge clk);
      check_handshake(hs, 3'b100, "idle");
    end
    report_test(1, "reset and idle handshake", base);

    base = errors;
    run_job(2'b10, 1'b0, 1'b1, BEATS_MAX, 1'b0, 1'b0);   // Longest job
    for (int m = 0; m < 4; m++) begin
      repeat (3) run_job(2'(m), 1'b0, 1'b1, $urandom_range(0, 40), 1'b0, 1'b0);
    end
    report_test(2, "unsigned accumulate", base);

    base = errors;
    for (int m = 0; m < 3; m++) begin
      repeat (4) run_job(2'(m), 1'b1, 1'b1, $urandom_range(0, 40), 1'b0, 1'b1);
    end
    report_test(3, "signed accumulate", base);

    base = errors;
    for (int m = 0; m < 3; m++) begin
      repeat (3) begin
        run_job(2'(m), 1'($urandom_range(0, 1)), 1'b0, $urandom_range(1, 20), 1'b0, 1'b1);
      end
    end
    report_test(4, "multiply only", base);

    base = errors;
    repeat (16) begin
      run_job(2'($urandom_range(0, 3)), 1'($urandom_range(0, 1)), 1'($urandom_range(0, 1)),
              $urandom_range(0, 24), 1'b1, 1'b1);
    end
    report_test(5, "beat gaps and result back-pressure", base);

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule
